// File: compile.f
verilog/vdf_pkg.sv
verilog/vdf_ctrl_fsm.sv
verilog/iter_counter.sv
verilog/stream_deser.sv
verilog/mod_squarer.sv
verilog/stream_ser.sv
verilog/vdf_top.sv
test/vdf_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the VDF squaring unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module vdf_tb -o vdf_sim

# The simulator exits non-zero on $fatal, the log decides the result
./obj_dir/vdf_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
   echo "Result: failure reported, see sim.log"
   exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
   echo "Result: run ended without a pass report, see sim.log"
   exit 1
fi
echo "Result: pass"

// File: test/vdf_tb.sv
// Self-checking testbench for vdf_top: runs several jobs under random stalls, checks by assertions
`timescale 1ns/1ps

module vdf_tb;

   localparam int          NUM_JOBS     = 8;
   localparam int          MAX_ITERS    = 6;
   localparam int          RESET_CYCLES = 8;
   // Worst job length times job count, plus reset
   localparam int          WATCHDOG_CYCLES = RESET_CYCLES +
      NUM_JOBS * (MAX_ITERS * (vdf_pkg::SQ_BITS + 2) + 50);
   // Prime 2^32 - 5, kept wide for the 64-bit reference product
   localparam logic [63:0] MODULUS_REF  = 64'd4294967291;

   logic        clk = 1'b0;
   logic        reset_1d;
   logic        ap_start;
   logic        s_tvalid;
   logic        s_tready;
   logic [31:0] s_tdata;
   logic        s_tlast;
   logic        m_tvalid;
   logic        m_tready = 1'b0;
   logic [31:0] m_tdata;
   logic        m_tlast;
   logic        start_xfer;
   logic        ap_done;

   // Stall pattern and scoreboard state
   int          seed = 18813;
   logic        stall_in = 1'b0;
   logic        job_open;
   logic [1:0]  out_idx;
   logic [1:0]  xfer_cnt;
   logic [31:0] prev_tdata;
   logic        prev_tlast;
   logic [31:0] exp_words [0:3];
   logic [31:0] exp_word;

   // Job parameters, drawn once at time zero
   logic [31:0] job_t_start [0:NUM_JOBS-1];
   logic [31:0] job_iters   [0:NUM_JOBS-1];
   logic [31:0] job_sq      [0:NUM_JOBS-1];

   always #2 clk = ~clk;

   vdf_top dut_i (
      .clk(clk), .reset_1d(reset_1d), .ap_start(ap_start),
      .s_tvalid(s_tvalid), .s_tready(s_tready), .s_tdata(s_tdata), .s_tlast(s_tlast),
      .m_tvalid(m_tvalid), .m_tready(m_tready), .m_tdata(m_tdata), .m_tlast(m_tlast),
      .start_xfer(start_xfer), .ap_done(ap_done)
   );

   ////////////////////////////////////////////////////////////
   // Reference model and helpers
   ////////////////////////////////////////////////////////////

   // x squared mod p, n times over
   function automatic logic [31:0] square_chain(input logic [31:0] x, input logic [31:0] n);
      logic [63:0] acc;
      acc = {32'd0, x} % MODULUS_REF;
      for (int i = 0; i < n; i++) begin
         acc = (acc * acc) % MODULUS_REF;
      end
      return acc[31:0];
   endfunction

   task stop_with_failure(input string reason);
      begin
         $display("%s", reason);
         $display("SIMULATION FAILED");
         $fatal(1, "Run stopped at first error");
      end
   endtask

   // One input word, with random idle gaps ahead of it
   task automatic send_word(input logic [31:0] data, input logic last);
      begin
         while (stall_in) begin
            s_tvalid <= 1'b0;
            @(posedge clk);
         end
         s_tvalid <= 1'b1;
         s_tdata  <= data;
         s_tlast  <= last;
         @(posedge clk);
         while (!s_tready) @(posedge clk);
         s_tvalid <= 1'b0;
         s_tlast  <= 1'b0;
      end
   endtask

   task automatic run_job(input int j);
      begin
         // Expected words: last index, seed word, result
         exp_words[0] = job_t_start[j] + job_iters[j] - 32'd1;
         exp_words[1] = 32'h0000_5A17;
         exp_words[2] = square_chain(job_sq[j], job_iters[j]);
         exp_words[3] = 32'd0;
         repeat (3) @(posedge clk);
         ap_start <= 1'b1;
         @(posedge clk);
         ap_start <= 1'b0;
         send_word(job_t_start[j], 1'b0);
         send_word(job_t_start[j] + job_iters[j], 1'b0);
         send_word(job_sq[j], 1'b1);
         @(posedge clk);
         while (!ap_done) @(posedge clk);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Stall generator and scoreboard bookkeeping
   ////////////////////////////////////////////////////////////

   // Both stall bits drawn in one process, one stream of numbers
   always @(posedge clk) begin
      stall_in <= ($unsigned($random(seed)) % 32'd3) == 32'd0;
      m_tready <= ($unsigned($random(seed)) % 32'd3) != 32'd0;
   end

   always @(posedge clk) begin
      prev_tdata <= m_tdata;
      prev_tlast <= m_tlast;
      if (reset_1d) begin
         job_open <= 1'b0;
         out_idx  <= 2'd0;
         xfer_cnt <= 2'd0;
      end else begin
         // New job clears the per-job counts
         if (ap_start) begin
            job_open <= 1'b1;
            out_idx  <= 2'd0;
            xfer_cnt <= 2'd0;
         end
         if (m_tvalid && m_tready) out_idx <= out_idx + 2'd1;
         if (start_xfer) xfer_cnt <= xfer_cnt + 2'd1;
         if (ap_done) job_open <= 1'b0;
      end
   end

   assign exp_word = exp_words[out_idx];

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // Outputs quiet between jobs and after reset
   a_quiet: assert property (@(posedge clk) disable iff (reset_1d)
      !job_open |-> !(s_tready || m_tvalid || ap_done || start_xfer))
      else stop_with_failure($sformatf(
         "[FAIL] %0t {s_tready,m_tvalid,ap_done,start_xfer} expected 0000 got %b", $time,
         $sampled({s_tready, m_tvalid, ap_done, start_xfer})));

   // Scoreboard compare on every output transfer
   a_word: assert property (@(posedge clk) disable iff (reset_1d)
      (m_tvalid && m_tready) |-> (m_tdata == exp_word))
      else stop_with_failure($sformatf("[FAIL] %0t m_tdata expected %h got %h",
         $time, $sampled(exp_word), $sampled(m_tdata)));

   a_no_extra: assert property (@(posedge clk) disable iff (reset_1d)
      m_tvalid |-> (out_idx < 2'd3))
      else stop_with_failure("Output stream offered a fourth word in one job");

   // Last flag on the third word only
   a_last: assert property (@(posedge clk) disable iff (reset_1d)
      m_tvalid |-> (m_tlast == (out_idx == 2'd2)))
      else stop_with_failure($sformatf("[FAIL] %0t m_tlast expected %b got %b",
         $time, $sampled(out_idx == 2'd2), $sampled(m_tlast)));

   // Held steady through a stall
   a_stall_valid: assert property (@(posedge clk) disable iff (reset_1d)
      (m_tvalid && !m_tready) |=> m_tvalid)
      else stop_with_failure($sformatf("[FAIL] %0t m_tvalid expected 1 got %b",
         $time, $sampled(m_tvalid)));

   a_stall_data: assert property (@(posedge clk) disable iff (reset_1d)
      (m_tvalid && !m_tready) |=> (m_tdata == prev_tdata))
      else stop_with_failure($sformatf("[FAIL] %0t m_tdata expected %h got %h",
         $time, $sampled(prev_tdata), $sampled(m_tdata)));

   a_stall_last: assert property (@(posedge clk) disable iff (reset_1d)
      (m_tvalid && !m_tready) |=> (m_tlast == prev_tlast))
      else stop_with_failure($sformatf("[FAIL] %0t m_tlast expected %b got %b",
         $time, $sampled(prev_tlast), $sampled(m_tlast)));

   // Exactly one start_xfer ahead of the output words
   a_xfer_once: assert property (@(posedge clk) disable iff (reset_1d)
      start_xfer |-> (xfer_cnt == 2'd0))
      else stop_with_failure("start_xfer pulsed more than once in one job");

   a_xfer_first: assert property (@(posedge clk) disable iff (reset_1d)
      m_tvalid |-> (xfer_cnt == 2'd1))
      else stop_with_failure("m_tvalid rose without exactly one start_xfer before it");

   // ap_done right after the last transfer, one cycle wide
   a_done_after: assert property (@(posedge clk) disable iff (reset_1d)
      (m_tvalid && m_tready && m_tlast) |=> ap_done)
      else stop_with_failure($sformatf("[FAIL] %0t ap_done expected 1 got %b",
         $time, $sampled(ap_done)));

   a_done_count: assert property (@(posedge clk) disable iff (reset_1d)
      ap_done |-> (out_idx == 2'd3))
      else stop_with_failure("ap_done came before all three output words were sent");

   a_done_single: assert property (@(posedge clk) disable iff (reset_1d)
      ap_done |=> !ap_done)
      else stop_with_failure($sformatf("[FAIL] %0t ap_done expected 0 got %b",
         $time, $sampled(ap_done)));

   ////////////////////////////////////////////////////////////
   // Main sequence and watchdog
   ////////////////////////////////////////////////////////////

   initial begin
      reset_1d = 1'b1;
      ap_start = 1'b0;
      s_tvalid = 1'b0;
      s_tdata  = 32'd0;
      s_tlast  = 1'b0;
      // Iteration counts cycle through 1 to 6
      for (int j = 0; j < NUM_JOBS; j++) begin
         job_t_start[j] = $unsigned($random(seed)) & 32'h00FF_FFFF;
         job_iters[j]   = 32'((j % MAX_ITERS) + 1);
         job_sq[j]      = $random(seed);
      end
      job_sq[0] = 32'd3;
      // Operand above the modulus
      job_sq[2] = 32'hFFFF_FFFD;
      repeat (RESET_CYCLES) @(posedge clk);
      reset_1d <= 1'b0;
      for (int j = 0; j < NUM_JOBS; j++) begin
         run_job(j);
      end
      // Let the trailing ap_done checks settle
      repeat (2) @(posedge clk);
      $display("SIMULATION PASSED");
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      stop_with_failure($sformatf("Timeout: run still busy after %0d cycles",
         WATCHDOG_CYCLES));
   end

endmodule

// File: verilog/iter_counter.sv
// Iteration counter: tracks t_current against t_final and flags the last squaring done
`timescale 1ns/1ps

module iter_counter (
   input  logic                       clk,
   input  logic                       reset_1d,
   input  logic                       load,
   input  logic [vdf_pkg::T_BITS-1:0] t_start,
   input  logic [vdf_pkg::T_BITS-1:0] t_final,
   input  logic                       sq_done,
   output logic                       final_iter,
   output logic [vdf_pkg::T_BITS-1:0] t_current
);

   localparam int TW = vdf_pkg::T_BITS;

   logic [TW-1:0] t_final_r;
   // Index of the last squaring
   logic [TW-1:0] t_last;
   // A job has been loaded
   logic          armed;

   assign t_last = t_final_r - TW'(1);

   // Done of the squaring that ends the job
   assign final_iter = sq_done && (t_current == t_last);

   always_ff @(posedge clk) begin
      if (load) begin
         t_current <= t_start;
         t_final_r <= t_final;
      end else if (sq_done && !final_iter) begin
         // Final done leaves t_current at t_final - 1
         t_current <= t_current + TW'(1);
      end
   end

   always_ff @(posedge clk) begin
      if (reset_1d) begin
         armed <= 1'b0;
      end else if (load) begin
         armed <= 1'b1;
      end
   end

   a_no_overrun: assert property (@(posedge clk) disable iff (reset_1d)
      armed |-> (t_current <= t_last));

endmodule

// File: verilog/mod_squarer.sv
// Bit-serial modular squarer: one squaring mod MODULUS per start, SQ_BITS + 1 cycles each
`timescale 1ns/1ps

module mod_squarer #(
   parameter int SQ_BITS = vdf_pkg::SQ_BITS
) (
   input  logic               clk,
   input  logic               reset_1d,
   input  logic               load,
   input  logic [SQ_BITS-1:0] sq_in,
   input  logic               sq_start,
   output logic               sq_done,
   output logic [SQ_BITS-1:0] sq_out
);

   localparam logic [SQ_BITS-1:0] MOD   = SQ_BITS'(vdf_pkg::MODULUS);
   localparam int                 CNT_W = $clog2(SQ_BITS + 1);

   logic [SQ_BITS-1:0] operand;
   // Multiplier bits, consumed from the top
   logic [SQ_BITS-1:0] mult;
   logic [SQ_BITS-1:0] acc;
   logic [SQ_BITS-1:0] acc_next;
   logic [SQ_BITS-1:0] dbl_mod;
   logic [SQ_BITS:0]   dbl;
   logic [SQ_BITS:0]   sum;
   logic [CNT_W-1:0]   cnt;
   logic               busy;

   ////////////////////////////////////////////////////////////
   // One interleaved step
   ////////////////////////////////////////////////////////////

   always_comb begin
      // 2*acc mod M
      dbl      = {acc, 1'b0};
      dbl_mod  = (dbl >= {1'b0, MOD}) ? SQ_BITS'(dbl - {1'b0, MOD}) : dbl[SQ_BITS-1:0];
      // Plus operand mod M when the bit is set
      sum      = {1'b0, dbl_mod} + {1'b0, operand};
      acc_next = dbl_mod;
      if (mult[SQ_BITS-1]) begin
         acc_next = (sum >= {1'b0, MOD}) ? SQ_BITS'(sum - {1'b0, MOD}) : sum[SQ_BITS-1:0];
      end
   end

   // Step counter, done lands SQ_BITS + 1 cycles after start
   always_ff @(posedge clk) begin
      if (reset_1d) begin
         busy    <= 1'b0;
         sq_done <= 1'b0;
         cnt     <= '0;
      end else begin
         sq_done <= 1'b0;
         if (sq_start) begin
            busy <= 1'b1;
            cnt  <= CNT_W'(SQ_BITS);
         end else if (busy) begin
            cnt <= cnt - CNT_W'(1);
            if (cnt == CNT_W'(1)) begin
               busy    <= 1'b0;
               sq_done <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      // Input may exceed M, one subtraction suffices
      if (load) begin
         operand <= (sq_in >= MOD) ? sq_in - MOD : sq_in;
      end else if (sq_done) begin
         operand <= acc;
      end
      if (sq_start) begin
         acc  <= '0;
         mult <= operand;
      end else if (busy) begin
         acc  <= acc_next;
         mult <= {mult[SQ_BITS-2:0], 1'b0};
      end
   end

   assign sq_out = acc;

   a_acc_reduced: assert property (@(posedge clk) disable iff (reset_1d)
      busy |=> (acc < MOD));

endmodule

// File: verilog/stream_deser.sv
// Input deserializer: collects the job words off the stream and splits out the fields
`timescale 1ns/1ps

module stream_deser #(
   parameter int WORD_BITS = vdf_pkg::WORD_BITS
) (
   input  logic                       clk,
   input  logic                       s_tvalid,
   input  logic                       s_tready,
   input  logic [WORD_BITS-1:0]       s_tdata,
   output logic [vdf_pkg::T_BITS-1:0] t_start,
   output logic [vdf_pkg::T_BITS-1:0] t_final,
   output logic [WORD_BITS-1:0]       sq_in
);

   localparam int TW      = vdf_pkg::T_BITS;
   localparam int IN_BITS = vdf_pkg::IN_WORDS * WORD_BITS;

   ////////////////////////////////////////////////////////////
   // Shift-in register
   ////////////////////////////////////////////////////////////

   // Oldest word ends at the bottom
   logic [IN_BITS-1:0] in_words;
   logic               accept;

   assign accept = s_tvalid && s_tready;

   always_ff @(posedge clk) begin
      if (accept) begin
         in_words <= {s_tdata, in_words[IN_BITS-1:WORD_BITS]};
      end
   end

   ////////////////////////////////////////////////////////////
   // Field slices
   ////////////////////////////////////////////////////////////

   // Word 0
   assign t_start = TW'(in_words[0*WORD_BITS +: WORD_BITS]);
   // Word 1
   assign t_final = TW'(in_words[1*WORD_BITS +: WORD_BITS]);
   // Word 2, the value to square
   assign sq_in   = in_words[2*WORD_BITS +: WORD_BITS];

endmodule

// File: verilog/stream_ser.sv
// Output serializer: holds the three result words and shifts them out on the stream
`timescale 1ns/1ps

module stream_ser #(
   parameter int WORD_BITS = vdf_pkg::WORD_BITS
) (
   input  logic                       clk,
   input  logic                       reset_1d,
   input  logic                       send_load,
   input  logic [vdf_pkg::T_BITS-1:0] t_current,
   input  logic [WORD_BITS-1:0]       sq_out,
   input  logic                       m_tvalid,
   input  logic                       m_tready,
   output logic [WORD_BITS-1:0]       m_tdata,
   output logic                       m_tlast,
   output logic                       last_beat
);

   localparam int OUT_BITS = vdf_pkg::OUT_WORDS * WORD_BITS;
   localparam int BEAT_W   = $clog2(vdf_pkg::OUT_WORDS + 1);

   logic [OUT_BITS-1:0] out_words;
   logic [BEAT_W-1:0]   beat;
   logic                xfer;

   assign xfer = m_tvalid && m_tready;

   // Payload, index at the bottom, result at the top
   always_ff @(posedge clk) begin
      if (send_load) begin
         out_words <= {sq_out, WORD_BITS'(vdf_pkg::BUILD_SEED), WORD_BITS'(t_current)};
      end else if (xfer) begin
         out_words <= {{WORD_BITS{1'b0}}, out_words[OUT_BITS-1:WORD_BITS]};
      end
   end

   // Beat count
   always_ff @(posedge clk) begin
      if (reset_1d || send_load) begin
         beat <= '0;
      end else if (xfer) begin
         beat <= beat + BEAT_W'(1);
      end
   end

   assign m_tdata   = out_words[WORD_BITS-1:0];
   assign m_tlast   = beat == BEAT_W'(vdf_pkg::OUT_WORDS - 1);
   assign last_beat = xfer && m_tlast;

   // Word and last flag held across a stall
   a_stall_stable: assert property (@(posedge clk) disable iff (reset_1d)
      (m_tvalid && !m_tready) |=> ($stable(m_tdata) && $stable(m_tlast)));

endmodule

// File: verilog/vdf_ctrl_fsm.sv
// Job controller: steps receive, load, squaring loop and send, and decodes all strobes
`timescale 1ns/1ps

module vdf_ctrl_fsm (
   input  logic clk,
   input  logic reset_1d,
   input  logic ap_start,
   input  logic s_tvalid,
   input  logic s_tlast,
   output logic s_tready,
   input  logic sq_done,
   input  logic final_iter,
   input  logic last_beat,
   output logic m_tvalid,
   output logic load,
   output logic sq_start,
   output logic send_load,
   output logic start_xfer,
   output logic ap_done
);

   vdf_pkg::ctrl_state_t state;
   vdf_pkg::ctrl_state_t next_state;

   // Pending re-issue after a non-final done
   logic reissue;
   // Delayed final flag, drives the output capture
   logic final_r;
   // Squaring in flight, tracked for the overlap check
   logic sq_busy;

   ////////////////////////////////////////////////////////////
   // State register and sequencing
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset_1d) begin
         state   <= vdf_pkg::INIT;
         reissue <= 1'b0;
         final_r <= 1'b0;
         sq_busy <= 1'b0;
      end else begin
         state   <= next_state;
         reissue <= sq_done && !final_iter;
         final_r <= final_iter;
         // Set on start, cleared on done
         if (sq_start) begin
            sq_busy <= 1'b1;
         end else if (sq_done) begin
            sq_busy <= 1'b0;
         end
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         vdf_pkg::INIT:         if (ap_start) next_state = vdf_pkg::RECV;
         // Last input word accepted
         vdf_pkg::RECV:         if (s_tvalid && s_tready && s_tlast) next_state = vdf_pkg::LOAD;
         vdf_pkg::LOAD:         next_state = vdf_pkg::START;
         vdf_pkg::START:        next_state = vdf_pkg::COMPUTE;
         vdf_pkg::COMPUTE:      if (final_iter) next_state = vdf_pkg::PREPARE_SEND;
         vdf_pkg::PREPARE_SEND: next_state = vdf_pkg::SEND;
         vdf_pkg::SEND:         if (last_beat) next_state = vdf_pkg::IDLE;
         vdf_pkg::IDLE:         next_state = vdf_pkg::INIT;
         default:               next_state = vdf_pkg::INIT;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Strobe decode
   ////////////////////////////////////////////////////////////

   assign s_tready   = state == vdf_pkg::RECV;
   assign m_tvalid   = state == vdf_pkg::SEND;
   assign load       = state == vdf_pkg::LOAD;
   // First squaring, then one per non-final done
   assign sq_start   = (state == vdf_pkg::START) || reissue;
   assign send_load  = final_r;
   assign start_xfer = state == vdf_pkg::PREPARE_SEND;
   assign ap_done    = state == vdf_pkg::IDLE;

   // No new squaring while the squarer is still running
   a_no_overlap: assert property (@(posedge clk) disable iff (reset_1d)
      sq_start |-> !sq_busy);

endmodule

// File: verilog/vdf_pkg.sv
// Shared widths, constants and FSM encoding for the VDF squaring unit; referenced by scoped name
package vdf_pkg;

   ////////////////////////////////////////////////////////////
   // Stream and operand widths
   ////////////////////////////////////////////////////////////

   // Width of one stream word on either side
   localparam int WORD_BITS = 32;
   // Iteration index width
   localparam int T_BITS    = 32;
   // Squaring operand width
   localparam int SQ_BITS   = 32;

   // Message lengths in words
   localparam int IN_WORDS  = 3;
   localparam int OUT_WORDS = 3;

   ////////////////////////////////////////////////////////////
   // Constants
   ////////////////////////////////////////////////////////////

   // Largest 32-bit prime, 2^32 - 5
   localparam logic [SQ_BITS-1:0] MODULUS = 32'd4294967291;

   // Returned in the low half of output word 1
   localparam logic [15:0] BUILD_SEED = 16'h5A17;

   // Controller states, in job order
   typedef enum logic [2:0] {
      INIT,
      RECV,
      LOAD,
      START,
      COMPUTE,
      PREPARE_SEND,
      SEND,
      IDLE
   } ctrl_state_t;

endpackage

// File: verilog/vdf_top.sv
// Top level of the VDF squaring unit: stream in a job, square repeatedly, stream back
`timescale 1ns/1ps

module vdf_top #(
   parameter int WORD_BITS = vdf_pkg::WORD_BITS,
   parameter int SQ_BITS   = vdf_pkg::SQ_BITS
) (
   input  logic                 clk,
   input  logic                 reset_1d,
   input  logic                 ap_start,
   input  logic                 s_tvalid,
   output logic                 s_tready,
   input  logic [WORD_BITS-1:0] s_tdata,
   input  logic                 s_tlast,
   output logic                 m_tvalid,
   input  logic                 m_tready,
   output logic [WORD_BITS-1:0] m_tdata,
   output logic                 m_tlast,
   output logic                 start_xfer,
   output logic                 ap_done
);

   // Controller strobes
   logic load;
   logic sq_start;
   logic sq_done;
   logic final_iter;
   logic send_load;
   logic last_beat;

   // Job fields and result
   logic [vdf_pkg::T_BITS-1:0] t_start;
   logic [vdf_pkg::T_BITS-1:0] t_final;
   logic [vdf_pkg::T_BITS-1:0] t_current;
   logic [WORD_BITS-1:0]       sq_in;
   logic [SQ_BITS-1:0]         sq_out;

   vdf_ctrl_fsm fsm_i (
      .clk(clk), .reset_1d(reset_1d), .ap_start(ap_start),
      .s_tvalid(s_tvalid), .s_tlast(s_tlast), .s_tready(s_tready),
      .sq_done(sq_done), .final_iter(final_iter), .last_beat(last_beat),
      .m_tvalid(m_tvalid), .load(load), .sq_start(sq_start),
      .send_load(send_load), .start_xfer(start_xfer), .ap_done(ap_done)
   );

   iter_counter cnt_i (
      .clk(clk), .reset_1d(reset_1d), .load(load), .t_start(t_start),
      .t_final(t_final), .sq_done(sq_done), .final_iter(final_iter),
      .t_current(t_current)
   );

   stream_deser #(.WORD_BITS(WORD_BITS)) deser_i (
      .clk(clk), .s_tvalid(s_tvalid), .s_tready(s_tready), .s_tdata(s_tdata),
      .t_start(t_start), .t_final(t_final), .sq_in(sq_in)
   );

   // Stream words resized to the operand width at the squarer
   mod_squarer #(.SQ_BITS(SQ_BITS)) sq_i (
      .clk(clk), .reset_1d(reset_1d), .load(load), .sq_in(SQ_BITS'(sq_in)),
      .sq_start(sq_start), .sq_done(sq_done), .sq_out(sq_out)
   );

   stream_ser #(.WORD_BITS(WORD_BITS)) ser_i (
      .clk(clk), .reset_1d(reset_1d), .send_load(send_load),
      .t_current(t_current), .sq_out(WORD_BITS'(sq_out)), .m_tvalid(m_tvalid),
      .m_tready(m_tready), .m_tdata(m_tdata), .m_tlast(m_tlast),
      .last_beat(last_beat)
   );

endmodule
